//--- rtl/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ALU operation select
    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;

    // Operand source picked by forwarding
    localparam int FWD_W = 2;
    localparam logic [FWD_W-1:0] FWD_REG   = 2'd0;
    localparam logic [FWD_W-1:0] FWD_EXMEM = 2'd1;
    localparam logic [FWD_W-1:0] FWD_MEMWB = 2'd2;

    // Instruction class handed from main control to ALU control
    localparam logic [1:0] ALUOP_MEM   = 2'd0;
    localparam logic [1:0] ALUOP_BEQ   = 2'd1;
    localparam logic [1:0] ALUOP_RTYPE = 2'd2;

endpackage

`default_nettype wire

//--- rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    // R-type function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // Same word seen as register or immediate format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

//--- rtl/mips_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

interface id_ex_if
    import mips_ctrl_pkg::*;
    import mips_isa_pkg::*;
();
    logic              reg_write, mem_to_reg, mem_read, mem_write;
    logic              branch, alu_src, reg_dst;
    logic [1:0]        alu_class;
    logic [XLEN-1:0]   pc4, rs_data, rt_data, imm;
    logic [REG_AW-1:0] rs, rt, rd;
    instr_t            instr;

    modport decode (output reg_write, mem_to_reg, mem_read, mem_write, branch, alu_src,
                    reg_dst, alu_class, pc4, rs_data, rt_data, imm, rs, rt, rd, instr);
    modport execute (input reg_write, mem_to_reg, mem_read, mem_write, branch, alu_src,
                     reg_dst, alu_class, pc4, rs_data, rt_data, imm, rs, rt, rd, instr);
endinterface

interface ex_mem_if
    import mips_ctrl_pkg::*;
();
    logic              reg_write, mem_to_reg, mem_read, mem_write, branch;
    logic              alu_zero;
    logic [XLEN-1:0]   alu_result, store_data, branch_target;
    logic [REG_AW-1:0] dest;

    modport execute (output reg_write, mem_to_reg, mem_read, mem_write, branch, alu_zero,
                     alu_result, store_data, dest, branch_target);
    modport memory (input reg_write, mem_to_reg, mem_read, mem_write, branch, alu_zero,
                    alu_result, store_data, dest);
    modport hazard (input branch, alu_zero);
endinterface

`default_nettype wire

//--- rtl/mips_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module mips_fetch
    import mips_ctrl_pkg::*;
    import mips_isa_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_step,
    input  wire             i_stall,
    input  wire             i_flush,
    input  wire [XLEN-1:0]  i_branch_target,
    input  wire             i_imem_we,
    input  wire [XLEN-1:0]  i_imem_addr,
    input  wire [XLEN-1:0]  i_imem_data,
    output logic [XLEN-1:0] o_pc,
    output instr_t          o_ifid_instr,
    output logic [XLEN-1:0] o_ifid_pc4
);
    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc4;

    assign pc4 = o_pc + XLEN'(4);

    // Debug loader writes whole words at a byte address
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr[IMEM_AW+1:2]] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc         <= '0;
            o_ifid_instr <= '0;
        end else if (i_step) begin
            if (i_flush) begin
                o_pc         <= i_branch_target;
                o_ifid_instr <= '0;
            end else if (!i_stall) begin
                o_pc         <= pc4;
                o_ifid_instr <= imem[o_pc[IMEM_AW+1:2]];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step && !i_stall) begin
            o_ifid_pc4 <= pc4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mips_decode
    import mips_ctrl_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_step,
    input  wire               i_flush,
    input  instr_t            i_ifid_instr,
    input  wire [XLEN-1:0]    i_ifid_pc4,
    input  wire               i_wb_we,
    input  wire [REG_AW-1:0]  i_wb_dest,
    input  wire [XLEN-1:0]    i_wb_data,
    input  wire [REG_AW-1:0]  i_dbg_reg_addr,
    output logic              o_stall,
    output logic [XLEN-1:0]   o_dbg_reg_data,
    id_ex_if.decode           idex,
    ex_mem_if.hazard          exm
);
    logic [XLEN-1:0] regs [32];
    logic            c_reg_write, c_mem_to_reg, c_mem_read, c_mem_write;
    logic            c_branch, c_alu_src, c_reg_dst;
    logic [1:0]      c_alu_class;
    logic            load_use;

    // Main control, unknown opcodes fall through as no-operations
    always_comb begin
        c_reg_write  = 1'b0;
        c_mem_to_reg = 1'b0;
        c_mem_read   = 1'b0;
        c_mem_write  = 1'b0;
        c_branch     = 1'b0;
        c_alu_src    = 1'b0;
        c_reg_dst    = 1'b0;
        c_alu_class  = ALUOP_MEM;
        case (i_ifid_instr.r.opcode)
            OP_RTYPE: begin
                c_reg_write = 1'b1;
                c_reg_dst   = 1'b1;
                c_alu_class = ALUOP_RTYPE;
            end
            OP_ADDI: begin
                c_reg_write = 1'b1;
                c_alu_src   = 1'b1;
            end
            OP_LW: begin
                c_reg_write  = 1'b1;
                c_mem_to_reg = 1'b1;
                c_mem_read   = 1'b1;
                c_alu_src    = 1'b1;
            end
            OP_SW: begin
                c_mem_write = 1'b1;
                c_alu_src   = 1'b1;
            end
            OP_BEQ: begin
                c_branch    = 1'b1;
                c_alu_class = ALUOP_BEQ;
            end
            default: ;
        endcase
    end

    // Register file read with write-back bypass
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb_we && i_wb_dest == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_step && i_wb_we && i_wb_dest != '0) begin
            regs[i_wb_dest] <= i_wb_data;
        end
    end

    always_comb begin
        o_dbg_reg_data = rf_read(i_dbg_reg_addr);
    end

    // Load in ID/EX feeding the instruction behind it
    assign load_use = idex.mem_read &&
                      (idex.rt == i_ifid_instr.i.rs || idex.rt == i_ifid_instr.i.rt);
    assign o_stall  = load_use && !(exm.branch && exm.alu_zero);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            {idex.reg_write, idex.mem_to_reg, idex.mem_read, idex.mem_write} <= '0;
            {idex.branch, idex.alu_src, idex.reg_dst} <= '0;
            idex.alu_class <= ALUOP_MEM;
        end else if (i_step) begin
            if (i_flush || load_use) begin
                {idex.reg_write, idex.mem_to_reg, idex.mem_read, idex.mem_write} <= '0;
                {idex.branch, idex.alu_src, idex.reg_dst} <= '0;
                idex.alu_class <= ALUOP_MEM;
            end else begin
                idex.reg_write  <= c_reg_write;
                idex.mem_to_reg <= c_mem_to_reg;
                idex.mem_read   <= c_mem_read;
                idex.mem_write  <= c_mem_write;
                idex.branch     <= c_branch;
                idex.alu_src    <= c_alu_src;
                idex.reg_dst    <= c_reg_dst;
                idex.alu_class  <= c_alu_class;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            idex.pc4     <= i_ifid_pc4;
            idex.rs_data <= rf_read(i_ifid_instr.i.rs);
            idex.rt_data <= rf_read(i_ifid_instr.i.rt);
            idex.imm     <= {{(XLEN-16){i_ifid_instr.i.imm[15]}}, i_ifid_instr.i.imm};
            idex.rs      <= i_ifid_instr.r.rs;
            idex.rt      <= i_ifid_instr.r.rt;
            idex.rd      <= i_ifid_instr.r.rd;
            idex.instr   <= i_ifid_instr;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_execute.sv
`timescale 1ns/100ps
`default_nettype none

module mips_execute
    import mips_ctrl_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_rst,
    input  wire              i_step,
    input  wire              i_flush,
    input  wire              i_wb_we,
    input  wire [REG_AW-1:0] i_wb_dest,
    input  wire [XLEN-1:0]   i_wb_data,
    id_ex_if.execute         idex,
    ex_mem_if.execute        exm
);
    logic [FWD_W-1:0]    fwd_a, fwd_b;
    logic [XLEN-1:0]     opnd_a, opnd_b_reg, opnd_b, alu_res;
    logic [ALU_OP_W-1:0] alu_op;

    // Newer result in EX/MEM wins over MEM/WB, register 0 is never forwarded
    function automatic logic [FWD_W-1:0] fwd_sel(input logic [REG_AW-1:0] src,
                                                 input logic ex_we,
                                                 input logic [REG_AW-1:0] ex_dest,
                                                 input logic wb_we,
                                                 input logic [REG_AW-1:0] wb_dest);
        if (src == '0) begin
            return FWD_REG;
        end
        if (ex_we && ex_dest == src) begin
            return FWD_EXMEM;
        end
        if (wb_we && wb_dest == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    function automatic logic [XLEN-1:0] fwd_mux(input logic [FWD_W-1:0] sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] ex_val,
                                                input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_EXMEM: return ex_val;
            FWD_MEMWB: return wb_val;
            default:   return reg_val;
        endcase
    endfunction

    assign fwd_a      = fwd_sel(idex.rs, exm.reg_write, exm.dest, i_wb_we, i_wb_dest);
    assign fwd_b      = fwd_sel(idex.rt, exm.reg_write, exm.dest, i_wb_we, i_wb_dest);
    assign opnd_a     = fwd_mux(fwd_a, idex.rs_data, exm.alu_result, i_wb_data);
    assign opnd_b_reg = fwd_mux(fwd_b, idex.rt_data, exm.alu_result, i_wb_data);
    assign opnd_b     = idex.alu_src ? idex.imm : opnd_b_reg;

    always_comb begin
        alu_op = ALU_ADD;
        case (idex.alu_class)
            ALUOP_BEQ: alu_op = ALU_SUB;
            ALUOP_RTYPE: begin
                case (idex.instr.r.funct)
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = opnd_a - opnd_b;
            ALU_AND: alu_res = opnd_a & opnd_b;
            ALU_OR:  alu_res = opnd_a | opnd_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            default: alu_res = opnd_a + opnd_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            {exm.reg_write, exm.mem_to_reg, exm.mem_read, exm.mem_write, exm.branch} <= '0;
        end else if (i_step) begin
            if (i_flush) begin
                {exm.reg_write, exm.mem_to_reg, exm.mem_read, exm.mem_write, exm.branch} <= '0;
            end else begin
                exm.reg_write  <= idex.reg_write;
                exm.mem_to_reg <= idex.mem_to_reg;
                exm.mem_read   <= idex.mem_read;
                exm.mem_write  <= idex.mem_write;
                exm.branch     <= idex.branch;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            exm.alu_zero      <= (alu_res == '0);
            exm.alu_result    <= alu_res;
            exm.store_data    <= opnd_b_reg;
            exm.dest          <= idex.reg_dst ? idex.rd : idex.rt;
            exm.branch_target <= idex.pc4 + {idex.imm[XLEN-3:0], 2'b00};
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_memory.sv
`timescale 1ns/100ps
`default_nettype none

module mips_memory
    import mips_ctrl_pkg::*;
#(
    parameter int DMEM_WORDS = 1024
) (
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_step,
    input  wire [XLEN-1:0]    i_dbg_mem_addr,
    output logic              o_flush,
    output logic [XLEN-1:0]   o_dbg_mem_data,
    output logic              o_wb_we,
    output logic [REG_AW-1:0] o_wb_dest,
    output logic [XLEN-1:0]   o_wb_data,
    ex_mem_if.memory          exm
);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic               wb_mem_to_reg;
    logic [XLEN-1:0]    wb_alu, wb_load;

    assign word_idx       = exm.alu_result[DMEM_AW+1:2];
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr[DMEM_AW+1:2]];

    // Taken beq
    assign o_flush = exm.branch && exm.alu_zero;

    always_ff @(posedge i_clk) begin
        if (i_step && exm.mem_write) begin
            dmem[word_idx] <= exm.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_we       <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else if (i_step) begin
            o_wb_we       <= exm.reg_write;
            wb_mem_to_reg <= exm.mem_to_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_wb_dest <= exm.dest;
            wb_alu    <= exm.alu_result;
            if (exm.mem_read) begin
                wb_load <= dmem[word_idx];
            end
        end
    end

    assign o_wb_data = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

`default_nettype wire

//--- rtl/mips_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_top
    import mips_ctrl_pkg::*;
    import mips_isa_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 1024
) (
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_step,
    input  wire               i_imem_we,
    input  wire [XLEN-1:0]    i_imem_addr,
    input  wire [XLEN-1:0]    i_imem_data,
    input  wire [REG_AW-1:0]  i_dbg_reg_addr,
    output wire [XLEN-1:0]    o_dbg_reg_data,
    input  wire [XLEN-1:0]    i_dbg_mem_addr,
    output wire [XLEN-1:0]    o_dbg_mem_data,
    output wire [XLEN-1:0]    o_pc
);
    instr_t            ifid_instr;
    logic [XLEN-1:0]   ifid_pc4;
    logic              stall, flush;
    logic              wb_we;
    logic [REG_AW-1:0] wb_dest;
    logic [XLEN-1:0]   wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    mips_fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step),
        .i_stall(stall), .i_flush(flush), .i_branch_target(ex_mem.branch_target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_pc(o_pc), .o_ifid_instr(ifid_instr), .o_ifid_pc4(ifid_pc4)
    );

    mips_decode u_decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step), .i_flush(flush),
        .i_ifid_instr(ifid_instr), .i_ifid_pc4(ifid_pc4),
        .i_wb_we(wb_we), .i_wb_dest(wb_dest), .i_wb_data(wb_data),
        .i_dbg_reg_addr(i_dbg_reg_addr), .o_stall(stall), .o_dbg_reg_data(o_dbg_reg_data),
        .idex(id_ex), .exm(ex_mem)
    );

    mips_execute u_execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step), .i_flush(flush),
        .i_wb_we(wb_we), .i_wb_dest(wb_dest), .i_wb_data(wb_data),
        .idex(id_ex), .exm(ex_mem)
    );

    mips_memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step), .i_dbg_mem_addr(i_dbg_mem_addr),
        .o_flush(flush), .o_dbg_mem_data(o_dbg_mem_data),
        .o_wb_we(wb_we), .o_wb_dest(wb_dest), .o_wb_data(wb_data),
        .exm(ex_mem)
    );

endmodule

`default_nettype wire

//--- bench/mips_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module mips_asserts
    import mips_ctrl_pkg::*;
(
    input wire            i_clk,
    input wire            i_rst,
    input wire            i_step,
    input wire            i_stall,
    input wire            i_flush,
    input wire [XLEN-1:0] i_target,
    input wire [XLEN-1:0] i_pc
);
    a_pc_reset: assert property (@(posedge i_clk) i_rst |=> i_pc == '0)
        else $error("o_pc is not zero after reset");

    a_pc_align: assert property (@(posedge i_clk) disable iff (i_rst) i_pc[1:0] == 2'b00)
        else $error("o_pc is not word aligned");

    // Pipeline frozen while stepping is off
    a_pc_hold: assert property (@(posedge i_clk) disable iff (i_rst) !i_step |=> $stable(i_pc))
        else $error("o_pc moved without a step");

    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step && i_stall |=> $stable(i_pc))
        else $error("o_pc moved during a stall");

    // A taken beq redirects fetch even with a load-use pending
    a_flush_wins: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step && i_flush |=> i_pc == $past(i_target))
        else $error("o_pc did not load the branch target on a flush");
endmodule

bind mips_top mips_asserts u_asserts (
    .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step),
    .i_stall(stall), .i_flush(flush), .i_target(ex_mem.branch_target), .i_pc(o_pc)
);

`default_nettype wire

//--- bench/tb_mips.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips
    import mips_isa_pkg::*;
();
    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 5;
    localparam int MAX_PROG   = 16;
    // Load, reset, drain, debug reads and the stall hold of one test
    localparam int TEST_CYCLES = MAX_PROG + 16 + (MAX_PROG + 8) + 2 * 12 + 20;

    logic        i_clk;
    logic        i_rst;
    logic        i_step;
    logic        i_imem_we;
    logic [31:0] i_imem_addr;
    logic [31:0] i_imem_data;
    logic [4:0]  i_dbg_reg_addr;
    logic [31:0] o_dbg_reg_data;
    logic [31:0] i_dbg_mem_addr;
    logic [31:0] o_dbg_mem_data;
    logic [31:0] o_pc;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    instr_t      prog [$];

    mips_top #(.IMEM_WORDS(256), .DMEM_WORDS(1024)) i_dut (
        .i_clk(i_clk), .i_rst(i_rst), .i_step(i_step),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .i_dbg_reg_addr(i_dbg_reg_addr), .o_dbg_reg_data(o_dbg_reg_data),
        .i_dbg_mem_addr(i_dbg_mem_addr), .o_dbg_mem_data(o_dbg_mem_data),
        .o_pc(o_pc)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic instr_t rtype(input logic [5:0] fn, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd);
        instr_t w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instr_t itype(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h, got %h", name, exp, act);
        end
    endtask

    // Writes the program under reset and ends it with a beq to itself
    task automatic load_program();
        prog.push_back(itype(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        @(posedge i_clk);
        i_rst  <= 1'b1;
        i_step <= 1'b0;
        foreach (prog[k]) begin
            i_imem_we   <= 1'b1;
            i_imem_addr <= k * 4;
            i_imem_data <= prog[k];
            @(posedge i_clk);
        end
        i_imem_we <= 1'b0;
        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    task automatic step_n(input int n);
        @(posedge i_clk);
        i_step <= 1'b1;
        repeat (n) @(posedge i_clk);
        i_step <= 1'b0;
    endtask

    task automatic check_reg(input logic [4:0] r, input logic [31:0] exp);
        @(posedge i_clk);
        i_dbg_reg_addr <= r;
        @(negedge i_clk);
        compare($sformatf("o_dbg_reg_data (r%0d)", r), exp, o_dbg_reg_data);
    endtask

    task automatic test_reset_fetch();
        logic [15:0] imm [7];
        prog.delete();
        // The last addi rewrites r1 after the frozen interval
        for (int k = 0; k < 7; k++) begin
            imm[k] = 16'(rand_bits(16));
            prog.push_back(itype(OP_ADDI, 5'd0, 5'(k % 6 + 1), imm[k]));
        end
        load_program();
        @(negedge i_clk);
        compare("o_pc", 32'd0, o_pc);
        for (int k = 1; k <= 6; k++) begin
            step_n(1);
            @(negedge i_clk);
            compare("o_pc", 32'(k * 4), o_pc);
        end
        check_reg(5'd1, sext(imm[0]));
        // Frozen pipeline
        repeat (20) @(posedge i_clk);
        @(negedge i_clk);
        compare("o_pc", 32'd24, o_pc);
        compare("o_dbg_reg_data (r1)", sext(imm[0]), o_dbg_reg_data);
        step_n(prog.size() + 8);
        check_reg(5'd1, sext(imm[6]));
        for (int k = 1; k < 6; k++) begin
            check_reg(5'(k + 1), sext(imm[k]));
        end
    endtask

    task automatic test_alu_forwarding();
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] x [1:8];
        a    = 16'(rand_bits(16));
        b    = 16'(rand_bits(16));
        x[1] = sext(a);
        x[2] = sext(b);
        x[3] = x[1] + x[2];
        x[4] = x[1] - x[3];
        x[5] = x[4] & x[3];
        x[6] = x[5] | x[1];
        x[7] = {31'd0, $signed(x[6]) < $signed(x[4])};
        x[8] = {31'd0, $signed(x[4]) < $signed(x[6])};
        prog.delete();
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd1, a));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd2, b));
        prog.push_back(rtype(FN_ADDU, 5'd1, 5'd2, 5'd3));
        prog.push_back(rtype(FN_SUBU, 5'd1, 5'd3, 5'd4));
        prog.push_back(rtype(FN_AND, 5'd4, 5'd3, 5'd5));
        prog.push_back(rtype(FN_OR, 5'd5, 5'd1, 5'd6));
        prog.push_back(rtype(FN_SLT, 5'd6, 5'd4, 5'd7));
        prog.push_back(rtype(FN_SLT, 5'd4, 5'd6, 5'd8));
        load_program();
        step_n(prog.size() + 8);
        for (int r = 1; r <= 8; r++) begin
            check_reg(5'(r), x[r]);
        end
    endtask

    task automatic test_load_store();
        logic [15:0] d;
        logic [15:0] o;
        logic [15:0] addr;
        d    = 16'(rand_bits(16));
        o    = 16'(rand_bits(16));
        addr = {4'd0, 10'(rand_bits(10)), 2'b00};
        prog.delete();
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd1, d));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd2, o));
        prog.push_back(itype(OP_SW, 5'd0, 5'd1, addr));
        prog.push_back(itype(OP_LW, 5'd0, 5'd3, addr));
        // Load-use on r3
        prog.push_back(rtype(FN_ADDU, 5'd3, 5'd2, 5'd4));
        load_program();
        step_n(prog.size() + 8);
        @(posedge i_clk);
        i_dbg_mem_addr <= {16'd0, addr};
        @(negedge i_clk);
        compare("o_dbg_mem_data", sext(d), o_dbg_mem_data);
        check_reg(5'd3, sext(d));
        check_reg(5'd4, sext(d) + sext(o));
    endtask

    task automatic test_branches();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v4;
        logic [15:0] v5;
        v1 = 16'(rand_bits(16));
        v2 = 16'(rand_bits(16));
        v4 = 16'(rand_bits(16));
        v5 = 16'(rand_bits(16));
        prog.delete();
        for (int r = 10; r <= 12; r++) begin
            prog.push_back(itype(OP_ADDI, 5'd0, 5'(r), 16'd0));
        end
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd13, v1));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd14, v1));
        prog.push_back(itype(OP_BEQ, 5'd13, 5'd14, 16'd3));
        for (int r = 10; r <= 12; r++) begin
            prog.push_back(itype(OP_ADDI, 5'd0, 5'(r), 16'(r)));
        end
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd15, v2));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd16, v1 ^ 16'd1));
        prog.push_back(itype(OP_BEQ, 5'd13, 5'd16, 16'd2));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd17, v4));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd18, v5));
        load_program();
        step_n(prog.size() + 8);
        for (int r = 10; r <= 12; r++) begin
            check_reg(5'(r), 32'd0);
        end
        check_reg(5'd15, sext(v2));
        check_reg(5'd17, sext(v4));
        check_reg(5'd18, sext(v5));
    endtask

    task automatic test_reg_zero();
        logic [15:0] a;
        logic [15:0] b;
        a = 16'(rand_bits(16)) | 16'd1;
        b = 16'(rand_bits(16));
        prog.delete();
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd0, a));
        prog.push_back(rtype(FN_OR, 5'd0, 5'd0, 5'd20));
        prog.push_back(itype(OP_ADDI, 5'd0, 5'd21, b));
        load_program();
        step_n(prog.size() + 8);
        check_reg(5'd0, 32'd0);
        check_reg(5'd20, 32'd0);
        check_reg(5'd21, sext(b));
    endtask

    initial begin
        #(2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not complete within the time limit");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        i_clk          = 1'b0;
        i_rst          = 1'b1;
        i_step         = 1'b0;
        i_imem_we      = 1'b0;
        i_imem_addr    = '0;
        i_imem_data    = '0;
        i_dbg_reg_addr = '0;
        i_dbg_mem_addr = '0;
        lfsr_state     = 32'hce890a1e;
        errors         = 0;
        checks         = 0;
        test_reset_fetch();
        test_alu_forwarding();
        test_load_store();
        test_branches();
        test_reg_zero();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mips_ctrl_pkg.sv
rtl/mips_isa_pkg.sv
rtl/mips_stage_if.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_memory.sv
rtl/mips_top.sv
bench/mips_asserts.sv
bench/tb_mips.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - rtl/mips_ctrl_pkg.sv
  - rtl/mips_isa_pkg.sv
  - rtl/mips_stage_if.sv
  - rtl/mips_fetch.sv
  - rtl/mips_decode.sv
  - rtl/mips_execute.sv
  - rtl/mips_memory.sv
  - rtl/mips_top.sv
  - target: test
    files:
      - bench/mips_asserts.sv
      - bench/tb_mips.sv
